// ==== src/ndn_pkg.sv ====
// *************************************************
// NDN FIB shared definitions
// Name, length and byte types, FSM encodings and
// the prefix mask and fold hash used by the table
// *************************************************
`default_nettype none

package ndn_pkg;

    // Name prefix, prefix length and payload byte
    typedef logic [63:0] prefix_t;
    typedef logic [5:0]  plen_t;
    typedef logic [7:0]  byte_t;

    // Longest-prefix-match engine states
    typedef enum logic [1:0] {LK_IDLE, LK_READ, LK_CHECK} lookup_state_t;

    // Data forwarding FSM states
    typedef enum logic [1:0] {FW_IDLE, FW_OFFER, FW_WAIT, FW_STREAM} fwd_state_t;

    // Keep only the top len bits of the prefix
    // A length of 0 shifts the mask out entirely
    function automatic prefix_t mask_prefix(input prefix_t p, input plen_t len);
        logic [6:0] shift;
        shift = 7'd64 - {1'b0, len};
        return p & (~64'd0 << shift);
    endfunction

    // XOR-fold 64 bits into width-sized chunks
    // Length goes into the low bits so each length gets its own spread
    function automatic logic [31:0] fold_hash(input prefix_t p, input plen_t len,
                                              input int width);
        logic [31:0] acc;
        logic [31:0] mask;
        acc = '0;
        mask = (32'd1 << width) - 32'd1;
        for (int i = 0; i < 64; i += width) begin
            acc ^= 32'(p >> i) & mask;
        end
        acc ^= 32'(len) & mask;
        return acc;
    endfunction

endpackage

`default_nettype wire

// ==== src/prefix_hash.sv ====
// *************************************************
// Prefix hash unit
// Masks a name to its length and folds it into a
// registered table index
// *************************************************
`default_nettype none

module prefix_hash #(
    parameter int HASH_W = 8
) (
    input  wire             clk,
    input  wire             rst,
    input  wire ndn_pkg::prefix_t prefix,
    input  wire ndn_pkg::plen_t   len,
    output logic [HASH_W-1:0]     index
);
    import ndn_pkg::*;

    // Masked name, so longer names with the same prefix share a slot
    prefix_t masked;

    assign masked = mask_prefix(prefix, len);

    // One cycle from input to index
    always_ff @(posedge clk) begin
        if (rst) begin
            index <= '0;
        end else begin
            index <= HASH_W'(fold_hash(masked, len, HASH_W));
        end
    end

endmodule

`default_nettype wire

// ==== src/fib_table.sv ====
// *************************************************
// FIB valid-bit table
// One 64-bit word per hash slot, one bit per length
// Cleared by a sweep after reset
// *************************************************
`default_nettype none

module fib_table #(
    parameter int HASH_W = 8
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 set_en,
    input  wire [HASH_W-1:0]    set_index,
    input  wire ndn_pkg::plen_t set_len,
    input  wire                 rd_en,
    input  wire [HASH_W-1:0]    rd_index,
    input  wire ndn_pkg::plen_t rd_len,
    output logic                rd_bit,
    output logic                fib_ready
);

    localparam int DEPTH = 2 ** HASH_W;

    logic [63:0]       mem [DEPTH];
    logic [HASH_W-1:0] sweep_idx;
    logic              sweeping;

    // Sweep control, one slot per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            sweeping  <= 1'b1;
            sweep_idx <= '0;
            fib_ready <= 1'b0;
        end else if (sweeping) begin
            sweep_idx <= sweep_idx + 1'b1;
            // Last slot cleared on this edge
            if (sweep_idx == HASH_W'(DEPTH - 1)) begin
                sweeping  <= 1'b0;
                fib_ready <= 1'b1;
            end
        end
    end

    // Single write port, shared by the sweep and the learn path
    always_ff @(posedge clk) begin
        if (sweeping && !rst) begin
            mem[sweep_idx] <= '0;
        end else if (set_en) begin
            mem[set_index][set_len] <= 1'b1;
        end
    end

    // Registered read of one valid bit
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_bit <= 1'b0;
        end else if (rd_en) begin
            rd_bit <= mem[rd_index][rd_len];
        end
    end

endmodule

`default_nettype wire

// ==== src/fib_learn.sv ====
// *************************************************
// FIB learn pipeline
// Hashes each arriving data prefix and sets its
// valid bit two cycles later
// *************************************************
`default_nettype none

module fib_learn #(
    parameter int HASH_W = 8
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   data_ready,
    input  wire ndn_pkg::prefix_t data_prefix,
    input  wire ndn_pkg::plen_t   data_len,
    input  wire [HASH_W-1:0]      hash_index,
    output ndn_pkg::prefix_t      hash_prefix,
    output ndn_pkg::plen_t        hash_len,
    output logic                  set_en,
    output logic [HASH_W-1:0]     set_index,
    output ndn_pkg::plen_t        set_len
);
    import ndn_pkg::*;

    // Stage one, alongside the hash register
    logic  hash_valid;
    plen_t hash_len_q;

    // Hash unit samples the prefix in the data_ready cycle
    assign hash_prefix = data_prefix;
    assign hash_len    = data_len;

    always_ff @(posedge clk) begin
        if (rst) begin
            hash_valid <= 1'b0;
            set_en     <= 1'b0;
        end else begin
            hash_valid <= data_ready;
            set_en     <= hash_valid;
        end
    end

    // Length rides along, index taken once the hash settles
    always_ff @(posedge clk) begin
        hash_len_q <= data_len;
        set_index  <= hash_index;
        set_len    <= hash_len_q;
    end

endmodule

`default_nettype wire

// ==== src/fib_lookup.sv ====
// *************************************************
// Longest-prefix-match engine
// Probes the table from the request length down and
// falls back to the default route at length 0
// *************************************************
`default_nettype none

module fib_lookup #(
    parameter int HASH_W = 8
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   lookup_start,
    input  wire ndn_pkg::prefix_t lookup_prefix,
    input  wire ndn_pkg::plen_t   lookup_len,
    input  wire [HASH_W-1:0]      hash_index,
    input  wire                   rd_bit,
    output ndn_pkg::prefix_t      hash_prefix,
    output ndn_pkg::plen_t        hash_len,
    output logic                  rd_en,
    output logic [HASH_W-1:0]     rd_index,
    output ndn_pkg::plen_t        rd_len,
    output logic                  lookup_idle,
    output ndn_pkg::prefix_t      match_prefix,
    output ndn_pkg::plen_t        match_len,
    output logic                  match_valid
);
    import ndn_pkg::*;

    lookup_state_t state;
    prefix_t       req_prefix;
    plen_t         cur_len;
    logic          search_done;

    // Hash runs one step ahead of the read
    // In idle it takes the request, in check the next shorter length
    always_comb begin
        if (state == LK_IDLE) begin
            hash_prefix = lookup_prefix;
            hash_len    = lookup_len;
        end else begin
            hash_prefix = req_prefix;
            hash_len    = cur_len - 6'd1;
        end
    end

    assign rd_en       = (state == LK_READ);
    assign rd_index    = hash_index;
    assign rd_len      = cur_len;
    assign lookup_idle = (state == LK_IDLE);

    // Hit, or a miss on the last nonzero length
    assign search_done = rd_bit || (cur_len == 6'd1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= LK_IDLE;
            match_valid <= 1'b0;
        end else begin
            match_valid <= 1'b0;
            case (state)
                LK_IDLE: begin
                    if (lookup_start) begin
                        // Length 0 is the default route straight away
                        if (lookup_len == '0) begin
                            match_valid <= 1'b1;
                        end else begin
                            state <= LK_READ;
                        end
                    end
                end
                LK_READ: state <= LK_CHECK;
                LK_CHECK: begin
                    if (search_done) begin
                        match_valid <= 1'b1;
                        state       <= LK_IDLE;
                    end else begin
                        state <= LK_READ;
                    end
                end
                default: state <= LK_IDLE;
            endcase
        end
    end

    // Request and result registers
    always_ff @(posedge clk) begin
        if (state == LK_IDLE && lookup_start) begin
            req_prefix   <= lookup_prefix;
            cur_len      <= lookup_len;
            match_prefix <= '0;
            match_len    <= '0;
        end else if (state == LK_CHECK) begin
            if (rd_bit) begin
                match_prefix <= mask_prefix(req_prefix, cur_len);
                match_len    <= cur_len;
            end else if (cur_len == 6'd1) begin
                match_prefix <= '0;
                match_len    <= '0;
            end else begin
                cur_len <= cur_len - 6'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/data_forward.sv ====
// *************************************************
// Data packet forwarding
// Offers a data prefix to the PIT and streams the
// payload under credit control, or drops it
// *************************************************
`default_nettype none

module data_forward #(
    parameter int PAYLOAD_BYTES = 16,
    parameter int CREDITS       = 4
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   data_ready,
    input  wire ndn_pkg::prefix_t data_prefix,
    input  wire ndn_pkg::plen_t   data_len,
    input  wire                   pit_accept,
    input  wire                   pit_reject,
    input  wire ndn_pkg::byte_t   data_in,
    input  wire                   data_in_valid,
    input  wire                   credit_return,
    output ndn_pkg::prefix_t      pit_out_prefix,
    output ndn_pkg::plen_t        pit_out_len,
    output logic                  prefix_ready,
    output logic                  ready_for_data,
    output logic                  data_take,
    output ndn_pkg::byte_t        out_data,
    output logic                  out_valid,
    output logic                  data_idle
);
    import ndn_pkg::*;

    localparam int CRED_W = $clog2(CREDITS + 1);
    localparam int CNT_W  = $clog2(PAYLOAD_BYTES + 1);

    fwd_state_t        state;
    logic [CRED_W-1:0] credits;
    logic [CNT_W-1:0]  byte_cnt;
    logic              last_byte;

    assign prefix_ready = (state == FW_OFFER);
    assign data_idle    = (state == FW_IDLE);

    // Move a byte only when one is offered and a credit is left
    assign data_take = (state == FW_STREAM) && data_in_valid && (credits != '0);
    assign last_byte = (byte_cnt == CNT_W'(PAYLOAD_BYTES - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= FW_IDLE;
            ready_for_data <= 1'b0;
            out_valid      <= 1'b0;
            byte_cnt       <= '0;
        end else begin
            ready_for_data <= 1'b0;
            out_valid      <= data_take;
            case (state)
                FW_IDLE: begin
                    if (data_ready) begin
                        state <= FW_OFFER;
                    end
                end
                FW_OFFER: state <= FW_WAIT;
                FW_WAIT: begin
                    // Rejected packets are simply dropped
                    if (pit_reject) begin
                        state <= FW_IDLE;
                    end else if (pit_accept) begin
                        state          <= FW_STREAM;
                        ready_for_data <= 1'b1;
                        byte_cnt       <= '0;
                    end
                end
                FW_STREAM: begin
                    if (data_take) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (last_byte) begin
                            state <= FW_IDLE;
                        end
                    end
                end
                default: state <= FW_IDLE;
            endcase
        end
    end

    // Credit counter, one down per byte sent, one up per return
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CRED_W'(CREDITS);
        end else begin
            credits <= credits + CRED_W'(credit_return) - CRED_W'(data_take);
        end
    end

    // Offered name and outgoing byte
    always_ff @(posedge clk) begin
        if (state == FW_IDLE && data_ready) begin
            pit_out_prefix <= data_prefix;
            pit_out_len    <= data_len;
        end
        if (data_take) begin
            out_data <= data_in;
        end
    end

endmodule

`default_nettype wire

// ==== src/fib.sv ====
// *************************************************
// NDN router FIB top level
// Learn and lookup paths around the valid-bit table,
// plus data forwarding toward the PIT
// *************************************************
`default_nettype none

module fib #(
    parameter int HASH_W        = 8,
    parameter int PAYLOAD_BYTES = 16,
    parameter int CREDITS       = 4
) (
    input  wire                   clk,
    input  wire                   rst,
    // Data side
    input  wire                   data_ready,
    input  wire ndn_pkg::prefix_t data_prefix,
    input  wire ndn_pkg::plen_t   data_len,
    input  wire ndn_pkg::byte_t   data_in,
    input  wire                   data_in_valid,
    output logic                  data_take,
    output logic                  ready_for_data,
    output logic                  data_idle,
    // PIT side
    output ndn_pkg::prefix_t      pit_out_prefix,
    output ndn_pkg::plen_t        pit_out_len,
    output logic                  prefix_ready,
    input  wire                   pit_accept,
    input  wire                   pit_reject,
    output ndn_pkg::byte_t        out_data,
    output logic                  out_valid,
    input  wire                   credit_return,
    // Lookup side
    input  wire                   lookup_start,
    input  wire ndn_pkg::prefix_t lookup_prefix,
    input  wire ndn_pkg::plen_t   lookup_len,
    output logic                  lookup_idle,
    output ndn_pkg::prefix_t      match_prefix,
    output ndn_pkg::plen_t        match_len,
    output logic                  match_valid,
    output logic                  fib_ready
);
    import ndn_pkg::*;

    // Learn path hash
    prefix_t           learn_hash_prefix;
    plen_t             learn_hash_len;
    logic [HASH_W-1:0] learn_hash_index;

    // Lookup path hash
    prefix_t           lookup_hash_prefix;
    plen_t             lookup_hash_len;
    logic [HASH_W-1:0] lookup_hash_index;

    // Table ports
    logic              set_en;
    logic [HASH_W-1:0] set_index;
    plen_t             set_len;
    logic              rd_en;
    logic [HASH_W-1:0] rd_index;
    plen_t             rd_len;
    logic              rd_bit;

    prefix_hash #(.HASH_W(HASH_W)) learn_hash (
        .clk(clk), .rst(rst),
        .prefix(learn_hash_prefix), .len(learn_hash_len),
        .index(learn_hash_index)
    );

    prefix_hash #(.HASH_W(HASH_W)) lookup_hash (
        .clk(clk), .rst(rst),
        .prefix(lookup_hash_prefix), .len(lookup_hash_len),
        .index(lookup_hash_index)
    );

    fib_table #(.HASH_W(HASH_W)) table_i (
        .clk(clk), .rst(rst),
        .set_en(set_en), .set_index(set_index), .set_len(set_len),
        .rd_en(rd_en), .rd_index(rd_index), .rd_len(rd_len),
        .rd_bit(rd_bit), .fib_ready(fib_ready)
    );

    // Every data packet teaches the table its prefix
    fib_learn #(.HASH_W(HASH_W)) learn_i (
        .clk(clk), .rst(rst),
        .data_ready(data_ready), .data_prefix(data_prefix), .data_len(data_len),
        .hash_index(learn_hash_index),
        .hash_prefix(learn_hash_prefix), .hash_len(learn_hash_len),
        .set_en(set_en), .set_index(set_index), .set_len(set_len)
    );

    fib_lookup #(.HASH_W(HASH_W)) lookup_i (
        .clk(clk), .rst(rst),
        .lookup_start(lookup_start), .lookup_prefix(lookup_prefix),
        .lookup_len(lookup_len),
        .hash_index(lookup_hash_index), .rd_bit(rd_bit),
        .hash_prefix(lookup_hash_prefix), .hash_len(lookup_hash_len),
        .rd_en(rd_en), .rd_index(rd_index), .rd_len(rd_len),
        .lookup_idle(lookup_idle),
        .match_prefix(match_prefix), .match_len(match_len),
        .match_valid(match_valid)
    );

    // Same data packets are offered to the PIT
    data_forward #(.PAYLOAD_BYTES(PAYLOAD_BYTES), .CREDITS(CREDITS)) forward_i (
        .clk(clk), .rst(rst),
        .data_ready(data_ready), .data_prefix(data_prefix), .data_len(data_len),
        .pit_accept(pit_accept), .pit_reject(pit_reject),
        .data_in(data_in), .data_in_valid(data_in_valid),
        .credit_return(credit_return),
        .pit_out_prefix(pit_out_prefix), .pit_out_len(pit_out_len),
        .prefix_ready(prefix_ready), .ready_for_data(ready_for_data),
        .data_take(data_take), .out_data(out_data), .out_valid(out_valid),
        .data_idle(data_idle)
    );

endmodule

`default_nettype wire

// ==== verification/fib_tb.sv ====
// *************************************************
// FIB testbench
// Random learn, lookup and forwarding traffic
// checked against a valid-bit model of the table
// *************************************************
`default_nettype none

module fib_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HASH_W        = 8;
    localparam int PAYLOAD_BYTES = 16;
    localparam int CREDITS       = 4;
    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 5;
    localparam int SWEEP_CYCLES  = 2 ** HASH_W;
    localparam int LEARN_COUNT   = 20;
    localparam int LPM_LOOKUPS   = 20;
    localparam int MISS_LOOKUPS  = 10;
    // Learns and lookups of all tests, plus two single packets
    localparam int N_OPS = 2 * LEARN_COUNT + 3 + LPM_LOOKUPS + 1 + MISS_LOOKUPS + 2;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + SWEEP_CYCLES + 600 * N_OPS;

    logic        clk;
    logic        rst;
    logic        data_ready;
    logic [63:0] data_prefix;
    logic [5:0]  data_len;
    logic [7:0]  data_in;
    logic        data_in_valid;
    logic        data_take;
    logic        ready_for_data;
    logic        data_idle;
    logic [63:0] pit_out_prefix;
    logic [5:0]  pit_out_len;
    logic        prefix_ready;
    logic        pit_accept;
    logic        pit_reject;
    logic [7:0]  out_data;
    logic        out_valid;
    logic        credit_return;
    logic        lookup_start;
    logic [63:0] lookup_prefix;
    logic [5:0]  lookup_len;
    logic        lookup_idle;
    logic [63:0] match_prefix;
    logic [5:0]  match_len;
    logic        match_valid;
    logic        fib_ready;

    int          seed = 32'h361a_4a2c;
    int          errors = 0;
    // Valid-bit model, one word per slot
    logic [63:0] model [SWEEP_CYCLES];
    logic [7:0]  payload_q [$];
    int          bytes_out = 0;
    int          rfd_count = 0;
    int          spent = 0;
    int          returned = 0;
    int          offers = 0;
    logic [63:0] offer_prefix;
    logic [5:0]  offer_len;
    // 0 random answer, 1 always reject, 2 always accept
    int          pit_mode = 0;

    fib #(
        .HASH_W(HASH_W), .PAYLOAD_BYTES(PAYLOAD_BYTES), .CREDITS(CREDITS)
    ) UUT (
        .clk(clk), .rst(rst),
        .data_ready(data_ready), .data_prefix(data_prefix), .data_len(data_len),
        .data_in(data_in), .data_in_valid(data_in_valid), .data_take(data_take),
        .ready_for_data(ready_for_data), .data_idle(data_idle),
        .pit_out_prefix(pit_out_prefix), .pit_out_len(pit_out_len),
        .prefix_ready(prefix_ready), .pit_accept(pit_accept), .pit_reject(pit_reject),
        .out_data(out_data), .out_valid(out_valid), .credit_return(credit_return),
        .lookup_start(lookup_start), .lookup_prefix(lookup_prefix),
        .lookup_len(lookup_len), .lookup_idle(lookup_idle),
        .match_prefix(match_prefix), .match_len(match_len),
        .match_valid(match_valid), .fib_ready(fib_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // Top len bits of the name, the rest zero
    function automatic logic [63:0] keep_top_bits(input logic [63:0] p, input logic [5:0] len);
        if (len == 6'd0) begin
            return 64'd0;
        end
        return p & ~((64'd1 << (7'd64 - len)) - 64'd1);
    endfunction

    // Bytes of the masked name XORed together, then the length
    function automatic logic [7:0] slot_index(input logic [63:0] p, input logic [5:0] len);
        logic [63:0] m;
        logic [7:0]  acc;
        m = keep_top_bits(p, len);
        acc = {2'b00, len};
        for (int b = 0; b < 8; b++) begin
            acc ^= m[b*8 +: 8];
        end
        return acc;
    endfunction

    // Longest length whose slot bit is set, aliases included
    task automatic expect_match(input logic [63:0] p, input logic [5:0] len,
                                output logic [63:0] exp_prefix, output logic [5:0] exp_len);
        logic found;
        found = 1'b0;
        exp_prefix = 64'd0;
        exp_len = 6'd0;
        for (int l = len; l >= 1; l--) begin
            if (!found && model[slot_index(p, 6'(l))][l]) begin
                found = 1'b1;
                exp_len = 6'(l);
                exp_prefix = keep_top_bits(p, 6'(l));
            end
        end
    endtask

    function automatic logic [63:0] random_name();
        return {$random(seed), $random(seed)};
    endfunction

    // One data packet, learned by the table and offered to the PIT
    task automatic send_packet(input string name, input logic [63:0] p, input logic [5:0] len);
        int offers_before;
        offers_before = offers;
        @(negedge clk);
        while (!data_idle) @(negedge clk);
        @(posedge clk);
        data_ready <= 1'b1;
        data_prefix <= p;
        data_len <= len;
        @(posedge clk);
        data_ready <= 1'b0;
        model[slot_index(p, len)][len] = 1'b1;
        @(negedge clk);
        while (!data_idle) @(negedge clk);
        check({name, " offer count"}, offers_before + 1, offers);
        check({name, " offer prefix"}, p, offer_prefix);
        check({name, " offer length"}, len, offer_len);
    endtask

    task automatic run_lookup(input string name, input logic [63:0] p, input logic [5:0] len,
                              output logic [5:0] got_len);
        logic [63:0] exp_prefix;
        logic [5:0]  exp_len;
        int          cycles;
        int          probes;
        expect_match(p, len, exp_prefix, exp_len);
        // Probes run from len down to the hit, or down to 1 on a miss
        probes = (exp_len != 0) ? (len - exp_len + 1) : len;
        @(negedge clk);
        while (!lookup_idle) @(negedge clk);
        @(posedge clk);
        lookup_start <= 1'b1;
        lookup_prefix <= p;
        lookup_len <= len;
        @(posedge clk);
        lookup_start <= 1'b0;
        cycles = 1;
        @(negedge clk);
        while (!match_valid) begin
            @(negedge clk);
            cycles++;
        end
        check({name, " length"}, exp_len, match_len);
        check({name, " prefix"}, exp_prefix, match_prefix);
        check({name, " latency"}, 2 * probes + 1, cycles);
        got_len = match_len;
    endtask

    // PIT answers each offer after a random delay
    initial begin : pit_responder
        int   delay;
        logic accept;
        pit_accept = 1'b0;
        pit_reject = 1'b0;
        forever begin
            @(negedge clk);
            if (prefix_ready) begin
                offers++;
                offer_prefix = pit_out_prefix;
                offer_len = pit_out_len;
                delay = $random(seed) & 3;
                case (pit_mode)
                    1: accept = 1'b0;
                    2: accept = 1'b1;
                    default: accept = ($random(seed) & 1) != 0;
                endcase
                repeat (delay) @(posedge clk);
                @(posedge clk);
                if (accept) begin
                    pit_accept <= 1'b1;
                end else begin
                    pit_reject <= 1'b1;
                end
                @(posedge clk);
                pit_accept <= 1'b0;
                pit_reject <= 1'b0;
            end
        end
    end

    // Upstream holds each byte until taken; valid comes and goes at random
    initial begin : upstream
        data_in = 8'd0;
        data_in_valid = 1'b0;
        forever begin
            @(negedge clk);
            if (data_take) begin
                payload_q.push_back(data_in);
            end
            if (data_take || !data_in_valid) begin
                @(posedge clk);
                data_in <= 8'($random(seed));
                data_in_valid <= ($random(seed) & 3) != 0;
            end
        end
    end

    // Sink checks bytes in order and hands credits back late
    initial begin : sink
        int         owed;
        logic [7:0] exp_byte;
        credit_return = 1'b0;
        owed = 0;
        forever begin
            @(negedge clk);
            if (data_take) begin
                spent++;
            end
            if (spent - returned > CREDITS) begin
                errors++;
                $display("More bytes in flight than credits allow at %0t", $time);
            end
            if (credit_return) begin
                returned++;
            end
            if (ready_for_data) begin
                rfd_count++;
            end
            if (out_valid) begin
                bytes_out++;
                owed++;
                if (payload_q.size() == 0) begin
                    errors++;
                    $display("Output byte appeared with no byte taken from upstream");
                end else begin
                    exp_byte = payload_q.pop_front();
                    check("payload byte", exp_byte, out_data);
                end
            end
            @(posedge clk);
            if (owed > 0 && ($random(seed) & 1) != 0) begin
                credit_return <= 1'b1;
                owed--;
            end else begin
                credit_return <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the DUT stopped answering before all tests were done");
        $display("Errors: %0d", errors);
        $display("Simulation failed");
        $finish;
    end

    initial begin : main
        logic [63:0] names [LEARN_COUNT];
        logic [5:0]  lens [LEARN_COUNT];
        logic [63:0] name;
        logic [5:0]  len;
        logic [5:0]  got_len;
        logic [63:0] exp_prefix;
        logic [5:0]  exp_len;
        int          cycles;
        int          tries;
        int          rfd_before;
        int          bytes_before;
        rst = 1'b1;
        data_ready = 1'b0;
        data_prefix = 64'd0;
        data_len = 6'd0;
        lookup_start = 1'b0;
        lookup_prefix = 64'd0;
        lookup_len = 6'd0;
        for (int i = 0; i < SWEEP_CYCLES; i++) begin
            model[i] = 64'd0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // 1: quiet outputs while the sweep clears the table
        cycles = 0;
        @(negedge clk);
        while (!fib_ready && cycles < SWEEP_CYCLES + 4) begin
            check("outputs during sweep", 5'd0,
                  {prefix_ready, ready_for_data, data_take, out_valid, match_valid});
            @(negedge clk);
            cycles++;
        end
        check("fib_ready latency", SWEEP_CYCLES, cycles);
        check("data_idle after sweep", 1'b1, data_idle);
        check("lookup_idle after sweep", 1'b1, lookup_idle);

        // 2: learn random names, then look each one up exactly
        for (int i = 0; i < LEARN_COUNT; i++) begin
            names[i] = random_name();
            lens[i] = 6'(1 + ($unsigned($random(seed)) % 63));
            send_packet($sformatf("learn %0d", i), names[i], lens[i]);
        end
        for (int i = 0; i < LEARN_COUNT; i++) begin
            run_lookup($sformatf("exact lookup %0d", i), names[i], lens[i], got_len);
            check($sformatf("exact lookup %0d reaches learned length", i), 1'b1,
                  got_len >= lens[i]);
        end

        // 3: nested prefixes of one name
        name = random_name();
        send_packet("nested 8", name, 6'd8);
        send_packet("nested 16", name, 6'd16);
        send_packet("nested 24", name, 6'd24);
        run_lookup("lpm length 0", name, 6'd0, got_len);
        for (int i = 0; i < LPM_LOOKUPS; i++) begin
            len = 6'($random(seed));
            run_lookup($sformatf("lpm lookup %0d", i), name, len, got_len);
        end

        // 4: names that land only on empty slots
        for (int i = 0; i < MISS_LOOKUPS; i++) begin
            tries = 0;
            do begin
                name = random_name();
                len = 6'($random(seed));
                expect_match(name, len, exp_prefix, exp_len);
                tries++;
            end while (exp_len != 6'd0 && tries < 100);
            run_lookup($sformatf("miss lookup %0d", i), name, len, got_len);
            check($sformatf("miss lookup %0d default route", i), 6'd0, got_len);
        end

        // 5: rejected packet is dropped
        pit_mode = 1;
        rfd_before = rfd_count;
        bytes_before = bytes_out;
        send_packet("rejected packet", random_name(), 6'd40);
        repeat (3) @(negedge clk);
        check("rejected packet ready_for_data", rfd_before, rfd_count);
        check("rejected packet bytes", bytes_before, bytes_out);

        // 6: accepted packet streams the full payload
        pit_mode = 2;
        rfd_before = rfd_count;
        bytes_before = bytes_out;
        send_packet("accepted packet", random_name(), 6'd33);
        repeat (3) @(negedge clk);
        check("accepted packet ready_for_data", rfd_before + 1, rfd_count);
        check("accepted packet bytes", bytes_before + PAYLOAD_BYTES, bytes_out);
        check("bytes left undelivered", 0, payload_q.size());
        pit_mode = 0;

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fib.f ====
src/ndn_pkg.sv
src/prefix_hash.sv
src/fib_table.sv
src/fib_learn.sv
src/fib_lookup.sv
src/data_forward.sv
src/fib.sv
verification/fib_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the FIB testbench with Verilator, run it, and judge the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal -f fib.f --top-module fib_tb -o fib_sim

./obj_dir/fib_sim > "$LOG" 2>&1
cat "$LOG"

if grep -q "Simulation passed" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
